/* Bender.yml */
package:
  name: exeStage

sources:
  - hdl/rvTypesPkg.sv
  - hdl/exeOpsPkg.sv
  - hdl/alu.sv
  - hdl/branchUnit.sv
  - hdl/mulDiv.sv
  - hdl/dataMem.sv
  - hdl/exeStage.sv
  - target: test
    files:
      - testbench/exeStageTb.sv

/* hdl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
(
	input  wire exeOpsPkg::aluOp_t     aluOp,
	input  wire rvTypesPkg::word_t     operandA,
	input  wire rvTypesPkg::word_t     operandB,
	input  wire exeOpsPkg::branchCmp_t branchCmp,
	input  wire                        branchNeg,
	output rvTypesPkg::word_t          result,
	output logic                       condMet
);

	logic       lessS;
	logic       lessU;
	logic       equal;
	logic [4:0] shamt;
	logic       cmpRaw;

	// comparators shared by slt/sltu and the branch condition
	assign lessS = $signed(operandA) < $signed(operandB);
	assign lessU = operandA < operandB;
	assign equal = operandA == operandB;
	assign shamt = operandB[4:0];

	always_comb
	begin
		case (aluOp)
			exeOpsPkg::aluAdd:  result = operandA + operandB;
			exeOpsPkg::aluSub:  result = operandA - operandB;
			exeOpsPkg::aluSll:  result = operandA << shamt;
			exeOpsPkg::aluSlt:  result = {31'b0, lessS};
			exeOpsPkg::aluSltu: result = {31'b0, lessU};
			exeOpsPkg::aluXor:  result = operandA ^ operandB;
			exeOpsPkg::aluSrl:  result = operandA >> shamt;
			exeOpsPkg::aluSra:  result = $signed(operandA) >>> shamt;
			exeOpsPkg::aluOr:   result = operandA | operandB;
			exeOpsPkg::aluAnd:  result = operandA & operandB;
			default:            result = '0;
		endcase
	end

	always_comb
	begin
		case (branchCmp)
			exeOpsPkg::cmpEq:  cmpRaw = equal;
			exeOpsPkg::cmpLt:  cmpRaw = lessS;
			exeOpsPkg::cmpLtu: cmpRaw = lessU;
			default:           cmpRaw = 1'b0;
		endcase
	end

	assign condMet = cmpRaw ^ branchNeg; // ne, ge, geu

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module branchUnit
(
	input  wire rvTypesPkg::pc_t   pc,
	input  wire rvTypesPkg::word_t operandA,
	input  wire rvTypesPkg::word_t operandB, // I immediate for jalr
	input  wire rvTypesPkg::word_t bImm,
	input  wire rvTypesPkg::word_t jImm,
	input  wire                    isBranch,
	input  wire                    isJal,
	input  wire                    isJalr,
	input  wire                    condMet,
	output rvTypesPkg::pc_t        target,
	output logic                   taken
);

	rvTypesPkg::pc_t jalrSum;

	assign jalrSum = operandA + operandB;

	// jumps are unconditional
	assign taken = isJal | isJalr | (isBranch & condMet);

	always_comb
	begin
		if (isJalr)
		begin
			target = {jalrSum[31:1], 1'b0}; // lsb cleared per spec
		end
		else if (isJal)
		begin
			target = pc + jImm;
		end
		else
		begin
			target = pc + bImm;
		end
	end

endmodule

`default_nettype wire

/* hdl/dataMem.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMem
#(
	parameter int memWords = 256
)
(
	input  wire                    clk,
	input  wire                    nrst,
	input  wire exeOpsPkg::memOp_t memOp,
	input  wire rvTypesPkg::word_t addr,
	input  wire rvTypesPkg::word_t storeData,
	output rvTypesPkg::word_t      loadData,
	output logic                   misaligned
);

	localparam int addrBits = $clog2(memWords);

	rvTypesPkg::word_t mem [memWords];

	logic [addrBits-1:0] wordIdx;
	logic                isHalf;
	logic                isWord;
	logic                misalNow;
	logic [3:0]          byteEn;
	rvTypesPkg::word_t   wrLanes;
	rvTypesPkg::word_t   rdWord;
	rvTypesPkg::word_t   rdShifted;
	logic [1:0]          rdOffset;
	exeOpsPkg::memOp_t   rdOp;

	assign wordIdx = addr[addrBits+1:2];

	assign isHalf  = memOp inside {exeOpsPkg::memLh, exeOpsPkg::memLhu, exeOpsPkg::memSh};
	assign isWord  = memOp inside {exeOpsPkg::memLw, exeOpsPkg::memSw};

	assign misalNow = (isHalf & addr[0]) | (isWord & (addr[1:0] != 2'b00));

	// lanes replicated so the byte enables alone pick the target bytes
	always_comb
	begin
		byteEn  = 4'b0000;
		wrLanes = storeData;
		case (memOp)
			exeOpsPkg::memSb:
			begin
				byteEn  = 4'b0001 << addr[1:0];
				wrLanes = {4{storeData[7:0]}};
			end
			exeOpsPkg::memSh:
			begin
				byteEn  = 4'b0011 << {addr[1], 1'b0};
				wrLanes = {2{storeData[15:0]}};
			end
			exeOpsPkg::memSw: byteEn = 4'b1111;
			default:          byteEn = 4'b0000;
		endcase
		if (misalNow)
			byteEn = 4'b0000; // misaligned store is dropped
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (byteEn[i])
				mem[wordIdx][8*i +: 8] <= wrLanes[8*i +: 8];
		end
		rdWord <= mem[wordIdx];
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdOffset   <= 2'b00;
			rdOp       <= exeOpsPkg::memNone;
			misaligned <= 1'b0;
		end
		else
		begin
			rdOffset   <= addr[1:0];
			rdOp       <= memOp;
			misaligned <= misalNow;
		end
	end

	assign rdShifted = rdWord >> {rdOffset, 3'b000}; // addressed lane to bit 0

	always_comb
	begin
		case (rdOp)
			exeOpsPkg::memLb:  loadData = {{24{rdShifted[7]}}, rdShifted[7:0]};
			exeOpsPkg::memLbu: loadData = {24'b0, rdShifted[7:0]};
			exeOpsPkg::memLh:  loadData = {{16{rdShifted[15]}}, rdShifted[15:0]};
			exeOpsPkg::memLhu: loadData = {16'b0, rdShifted[15:0]};
			exeOpsPkg::memLw:  loadData = rdWord;
			default:           loadData = '0; // stores and idle
		endcase
	end

endmodule

`default_nettype wire

/* hdl/exeOpsPkg.sv */
`default_nettype none

package exeOpsPkg;

	typedef enum logic [3:0]
	{
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOp_t;

	// RV32M, same order as funct3
	typedef enum logic [2:0]
	{
		mdMul    = 3'd0,
		mdMulh   = 3'd1,
		mdMulhsu = 3'd2,
		mdMulhu  = 3'd3,
		mdDiv    = 3'd4,
		mdDivu   = 3'd5,
		mdRem    = 3'd6,
		mdRemu   = 3'd7
	} mulDivOp_t;

	typedef enum logic [3:0]
	{
		memNone = 4'd0,
		memLb   = 4'd1,
		memLh   = 4'd2,
		memLw   = 4'd3,
		memLbu  = 4'd4,
		memLhu  = 4'd5,
		memSb   = 4'd6,
		memSh   = 4'd7,
		memSw   = 4'd8
	} memOp_t;

	// writeback source, picked in pipe 6
	typedef enum logic [2:0]
	{
		wbAluRes    = 3'd0,
		wbPcNext    = 3'd1,
		wbMulDivRes = 3'd2,
		wbUpperImm  = 3'd3,
		wbMemData   = 3'd4,
		wbAuipcRes  = 3'd5
	} wbSel_t;

	// bne/bge/bgeu are these with branchNeg set
	typedef enum logic [1:0]
	{
		cmpEq  = 2'd0,
		cmpLt  = 2'd1,
		cmpLtu = 2'd2
	} branchCmp_t;

endpackage

`default_nettype wire

/* hdl/exeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module exeStage
#(
	parameter int memWords = 256
)
(
	input  wire                        clk,
	input  wire                        nrst,
	input  wire rvTypesPkg::word_t     opA,
	input  wire rvTypesPkg::word_t     opB,
	input  wire rvTypesPkg::regAddr_t  rd,
	input  wire                        regWe,
	input  wire exeOpsPkg::aluOp_t     aluOp,
	input  wire exeOpsPkg::mulDivOp_t  mulDivOp,
	input  wire exeOpsPkg::memOp_t     memOp,
	input  wire exeOpsPkg::wbSel_t     wbSel,
	input  wire exeOpsPkg::branchCmp_t branchCmp,
	input  wire                        branchNeg,
	input  wire                        isBranch,
	input  wire                        isJal,
	input  wire                        isJalr,
	input  wire rvTypesPkg::word_t     bImm,
	input  wire rvTypesPkg::word_t     jImm,
	input  wire rvTypesPkg::word_t     uImm,
	input  wire rvTypesPkg::word_t     sImm,
	input  wire rvTypesPkg::pc_t       pc,
	output rvTypesPkg::word_t          wbData,
	output rvTypesPkg::regAddr_t       wbRd,
	output logic                       wbWe,
	output logic                       addrMisaligned,
	output rvTypesPkg::pc_t            branchTarget,
	output logic                       branchTaken
);

	// pipe 5
	rvTypesPkg::word_t     opA5;
	rvTypesPkg::word_t     opB5;
	rvTypesPkg::regAddr_t  rd5;
	logic                  regWe5;
	exeOpsPkg::aluOp_t     aluOp5;
	exeOpsPkg::mulDivOp_t  mulDivOp5;
	exeOpsPkg::memOp_t     memOp5;
	exeOpsPkg::wbSel_t     wbSel5;
	exeOpsPkg::branchCmp_t branchCmp5;
	logic                  branchNeg5;
	logic                  isBranch5;
	logic                  isJal5;
	logic                  isJalr5;
	rvTypesPkg::word_t     bImm5;
	rvTypesPkg::word_t     jImm5;
	rvTypesPkg::word_t     uImm5;
	rvTypesPkg::word_t     sImm5;
	rvTypesPkg::pc_t       pc5;

	rvTypesPkg::word_t     aluRes5;
	logic                  condMet5;
	rvTypesPkg::word_t     mulDivRes5;
	logic                  isStore5;
	rvTypesPkg::word_t     memAddr5;

	// pipe 6
	rvTypesPkg::word_t     aluRes6;
	rvTypesPkg::word_t     mulDivRes6;
	rvTypesPkg::word_t     uImm6;
	rvTypesPkg::word_t     auipcRes6;
	rvTypesPkg::pc_t       pc6;
	exeOpsPkg::wbSel_t     wbSel6;
	rvTypesPkg::word_t     loadData6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5       <= '0;
			opB5       <= '0;
			rd5        <= '0;
			regWe5     <= 1'b0;
			aluOp5     <= exeOpsPkg::aluAdd;
			mulDivOp5  <= exeOpsPkg::mdMul;
			memOp5     <= exeOpsPkg::memNone;
			wbSel5     <= exeOpsPkg::wbAluRes;
			branchCmp5 <= exeOpsPkg::cmpEq;
			branchNeg5 <= 1'b0;
			isBranch5  <= 1'b0;
			isJal5     <= 1'b0;
			isJalr5    <= 1'b0;
			bImm5      <= '0;
			jImm5      <= '0;
			uImm5      <= '0;
			sImm5      <= '0;
			pc5        <= '0;
		end
		else
		begin
			opA5       <= opA;
			opB5       <= opB;
			rd5        <= rd;
			regWe5     <= regWe;
			aluOp5     <= aluOp;
			mulDivOp5  <= mulDivOp;
			memOp5     <= memOp;
			wbSel5     <= wbSel;
			branchCmp5 <= branchCmp;
			branchNeg5 <= branchNeg;
			isBranch5  <= isBranch;
			isJal5     <= isJal;
			isJalr5    <= isJalr;
			bImm5      <= bImm;
			jImm5      <= jImm;
			uImm5      <= uImm;
			sImm5      <= sImm;
			pc5        <= pc;
		end
	end

	alu alu_i
	(
		.aluOp     (aluOp5),
		.operandA  (opA5),
		.operandB  (opB5),
		.branchCmp (branchCmp5),
		.branchNeg (branchNeg5),
		.result    (aluRes5),
		.condMet   (condMet5)
	);

	branchUnit branchUnit_i
	(
		.pc       (pc5),
		.operandA (opA5),
		.operandB (opB5),
		.bImm     (bImm5),
		.jImm     (jImm5),
		.isBranch (isBranch5),
		.isJal    (isJal5),
		.isJalr   (isJalr5),
		.condMet  (condMet5),
		.target   (branchTarget),
		.taken    (branchTaken)
	);

	mulDiv mulDiv_i
	(
		.a   (opA5),
		.b   (opB5),
		.op  (mulDivOp5),
		.res (mulDivRes5)
	);

	// stores take their offset from sImm, loads get the I immediate in opB
	assign isStore5 = memOp5 inside {exeOpsPkg::memSb, exeOpsPkg::memSh, exeOpsPkg::memSw};
	assign memAddr5 = opA5 + (isStore5 ? sImm5 : opB5);

	dataMem #(.memWords(memWords)) dataMem_i
	(
		.clk        (clk),
		.nrst       (nrst),
		.memOp      (memOp5),
		.addr       (memAddr5),
		.storeData  (opB5), // rs2 value
		.loadData   (loadData6),
		.misaligned (addrMisaligned)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6    <= '0;
			mulDivRes6 <= '0;
			uImm6      <= '0;
			auipcRes6  <= '0;
			pc6        <= '0;
			wbRd       <= '0;
			wbWe       <= 1'b0;
			wbSel6     <= exeOpsPkg::wbAluRes;
		end
		else
		begin
			aluRes6    <= aluRes5;
			mulDivRes6 <= mulDivRes5;
			uImm6      <= uImm5;
			auipcRes6  <= pc5 + uImm5;
			pc6        <= pc5;
			wbRd       <= rd5;
			wbWe       <= regWe5;
			wbSel6     <= wbSel5;
		end
	end

	always_comb
	begin
		case (wbSel6)
			exeOpsPkg::wbAluRes:    wbData = aluRes6;
			exeOpsPkg::wbPcNext:    wbData = pc6 + rvTypesPkg::instrBytes; // link address
			exeOpsPkg::wbMulDivRes: wbData = mulDivRes6;
			exeOpsPkg::wbUpperImm:  wbData = uImm6;
			exeOpsPkg::wbMemData:   wbData = loadData6;
			exeOpsPkg::wbAuipcRes:  wbData = auipcRes6;
			default:                wbData = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/mulDiv.sv */
`timescale 1ns/100ps
`default_nettype none

module mulDiv
(
	input  wire rvTypesPkg::word_t    a,
	input  wire rvTypesPkg::word_t    b,
	input  wire exeOpsPkg::mulDivOp_t op,
	output rvTypesPkg::word_t         res
);

	logic signed [63:0] prodSs;
	logic signed [63:0] prodSu;
	logic        [63:0] prodUu;
	logic               divZero;
	logic               divOvf;
	rvTypesPkg::word_t  safeB;
	rvTypesPkg::word_t  quotS;
	rvTypesPkg::word_t  quotU;
	rvTypesPkg::word_t  remS;
	rvTypesPkg::word_t  remU;

	// 64-bit products, low half is the same for all three
	assign prodSs = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	assign prodSu = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
	assign prodUu = {32'b0, a} * {32'b0, b};

	assign divZero = (b == '0);
	assign divOvf  = (a == 32'h8000_0000) && (b == '1);
	assign safeB   = divZero ? 32'd1 : b; // keeps the dividers free of x

	assign quotS = $signed(a) / $signed(safeB);
	assign remS  = $signed(a) % $signed(safeB);
	assign quotU = a / safeB;
	assign remU  = a % safeB;

	always_comb
	begin
		case (op)
			exeOpsPkg::mdMul:    res = prodUu[31:0];
			exeOpsPkg::mdMulh:   res = prodSs[63:32];
			exeOpsPkg::mdMulhsu: res = prodSu[63:32];
			exeOpsPkg::mdMulhu:  res = prodUu[63:32];
			exeOpsPkg::mdDiv:    res = divZero ? '1 : (divOvf ? a : quotS);
			exeOpsPkg::mdDivu:   res = divZero ? '1 : quotU;
			exeOpsPkg::mdRem:    res = divZero ? a : (divOvf ? '0 : remS);
			exeOpsPkg::mdRemu:   res = divZero ? a : remU;
			default:             res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/rvTypesPkg.sv */
`default_nettype none

package rvTypesPkg;

	// architectural data word
	typedef logic [31:0] word_t;

	// index into the integer register file
	typedef logic [4:0] regAddr_t;

	// byte address of an instruction
	typedef logic [31:0] pc_t;

	localparam word_t instrBytes = 32'd4; // no compressed instructions

endpackage

`default_nettype wire

/* sources.f */
hdl/rvTypesPkg.sv
hdl/exeOpsPkg.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/mulDiv.sv
hdl/dataMem.sv
hdl/exeStage.sv
testbench/exeStageTb.sv

/* testbench/exeStageTb.sv */
`timescale 1ns/100ps
`default_nettype none

module exeStageTb;

	localparam int memWords  = 256;
	localparam int aluCount  = 200;
	localparam int mdCount   = 120;
	localparam int brReps    = 4;
	localparam int memRounds = 30;
	localparam int misRounds = 8;
	localparam int drainLen  = 3;
	// all test lengths in cycles plus a margin of 100
	localparam int cycleLimit = 6 + aluCount + (mdCount + 6) + (6 * 3 * brReps + 4)
		+ (memWords + memRounds * 6 + misRounds * 3) + 12 + 5 * drainLen + 100;

	typedef struct packed
	{
		rvTypesPkg::word_t     opA;
		rvTypesPkg::word_t     opB;
		rvTypesPkg::regAddr_t  rd;
		logic                  regWe;
		exeOpsPkg::aluOp_t     aluOp;
		exeOpsPkg::mulDivOp_t  mulDivOp;
		exeOpsPkg::memOp_t     memOp;
		exeOpsPkg::wbSel_t     wbSel;
		exeOpsPkg::branchCmp_t branchCmp;
		logic                  branchNeg;
		logic                  isBranch;
		logic                  isJal;
		logic                  isJalr;
		rvTypesPkg::word_t     bImm;
		rvTypesPkg::word_t     jImm;
		rvTypesPkg::word_t     uImm;
		rvTypesPkg::word_t     sImm;
		rvTypesPkg::pc_t       pc;
	} instr_t; // all-zero decodes as add, no memory op, aluRes

	typedef struct packed
	{
		logic                 valid;
		logic                 chkData;
		rvTypesPkg::word_t    data;
		rvTypesPkg::regAddr_t rd;
		logic                 we;
		logic                 mis;
		logic                 taken;
		rvTypesPkg::pc_t      target;
	} expect_t;

	logic                 clk = 1'b0;
	logic                 nrst;
	instr_t               cur;
	expect_t              expIn;
	expect_t              exp5 = '0; // model of pipe 5
	expect_t              exp6 = '0; // model of pipe 6
	rvTypesPkg::word_t    wbData;
	rvTypesPkg::regAddr_t wbRd;
	logic                 wbWe;
	logic                 addrMisaligned;
	rvTypesPkg::pc_t      branchTarget;
	logic                 branchTaken;
	rvTypesPkg::word_t    shadow [memWords];
	int                   seed = 32'hb379abdb;
	int                   errCount = 0;
	int                   errAtStart = 0;
	int                   testsRun = 0;
	int                   testsFailed = 0;
	int                   cycleCount = 0;

	always #4 clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	exeStage #(.memWords(memWords)) dut_i
	(
		.clk            (clk),
		.nrst           (nrst),
		.opA            (cur.opA),
		.opB            (cur.opB),
		.rd             (cur.rd),
		.regWe          (cur.regWe),
		.aluOp          (cur.aluOp),
		.mulDivOp       (cur.mulDivOp),
		.memOp          (cur.memOp),
		.wbSel          (cur.wbSel),
		.branchCmp      (cur.branchCmp),
		.branchNeg      (cur.branchNeg),
		.isBranch       (cur.isBranch),
		.isJal          (cur.isJal),
		.isJalr         (cur.isJalr),
		.bImm           (cur.bImm),
		.jImm           (cur.jImm),
		.uImm           (cur.uImm),
		.sImm           (cur.sImm),
		.pc             (cur.pc),
		.wbData         (wbData),
		.wbRd           (wbRd),
		.wbWe           (wbWe),
		.addrMisaligned (addrMisaligned),
		.branchTarget   (branchTarget),
		.branchTaken    (branchTaken)
	);

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			exp5 <= '0;
			exp6 <= '0;
		end
		else
		begin
			exp5 <= expIn;
			exp6 <= exp5;
		end
	end

	task automatic reportMismatch(input string name, input logic [31:0] expv,
		input logic [31:0] act);
		$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expv, act);
		errCount++;
	endtask

	// writeback checks two cycles after issue, branch checks one cycle after
	assert property (@(posedge clk) disable iff (!nrst) exp6.valid |-> wbWe == exp6.we)
		else reportMismatch("wbWe", $sampled(exp6.we), $sampled(wbWe));
	assert property (@(posedge clk) disable iff (!nrst) exp6.valid |-> wbRd == exp6.rd)
		else reportMismatch("wbRd", $sampled(exp6.rd), $sampled(wbRd));
	assert property (@(posedge clk) disable iff (!nrst)
		exp6.valid && exp6.chkData |-> wbData == exp6.data)
		else reportMismatch("wbData", $sampled(exp6.data), $sampled(wbData));
	assert property (@(posedge clk) disable iff (!nrst)
		exp6.valid |-> addrMisaligned == exp6.mis)
		else reportMismatch("addrMisaligned", $sampled(exp6.mis), $sampled(addrMisaligned));
	assert property (@(posedge clk) disable iff (!nrst)
		exp5.valid |-> branchTaken == exp5.taken)
		else reportMismatch("branchTaken", $sampled(exp5.taken), $sampled(branchTaken));
	assert property (@(posedge clk) disable iff (!nrst)
		exp5.valid && exp5.taken |-> branchTarget == exp5.target)
		else reportMismatch("branchTarget", $sampled(exp5.target), $sampled(branchTarget));

	function automatic logic lessSigned(input rvTypesPkg::word_t a, input rvTypesPkg::word_t b);
		return (a[31] != b[31]) ? a[31] : (a < b);
	endfunction

	function automatic rvTypesPkg::word_t refAlu(input exeOpsPkg::aluOp_t op,
		input rvTypesPkg::word_t a, input rvTypesPkg::word_t b);
		case (op)
			exeOpsPkg::aluAdd:  return a + b;
			exeOpsPkg::aluSub:  return a - b;
			exeOpsPkg::aluSll:  return a << b[4:0];
			exeOpsPkg::aluSlt:  return {31'b0, lessSigned(a, b)};
			exeOpsPkg::aluSltu: return {31'b0, a < b};
			exeOpsPkg::aluXor:  return a ^ b;
			exeOpsPkg::aluSrl:  return a >> b[4:0];
			exeOpsPkg::aluSra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
			exeOpsPkg::aluOr:   return a | b;
			default:            return a & b;
		endcase
	endfunction

	function automatic logic refCond(input exeOpsPkg::branchCmp_t cmp, input logic neg,
		input rvTypesPkg::word_t a, input rvTypesPkg::word_t b);
		logic raw;
		case (cmp)
			exeOpsPkg::cmpEq: raw = (a == b);
			exeOpsPkg::cmpLt: raw = lessSigned(a, b);
			default:          raw = (a < b);
		endcase
		return raw != neg;
	endfunction

	function automatic rvTypesPkg::word_t refMulDiv(input exeOpsPkg::mulDivOp_t op,
		input rvTypesPkg::word_t a, input rvTypesPkg::word_t b);
		logic [63:0]       prod;
		rvTypesPkg::word_t magA;
		rvTypesPkg::word_t magB;
		prod = {32'b0, a} * {32'b0, b};
		magA = a[31] ? -a : a;
		magB = b[31] ? -b : b;
		// signed high halves corrected from the unsigned product
		case (op)
			exeOpsPkg::mdMul:    return prod[31:0];
			exeOpsPkg::mdMulh:   return prod[63:32] - (a[31] ? b : 32'd0) - (b[31] ? a : 32'd0);
			exeOpsPkg::mdMulhsu: return prod[63:32] - (a[31] ? b : 32'd0);
			exeOpsPkg::mdMulhu:  return prod[63:32];
			default:             ;
		endcase
		if (b == '0)
			return (op inside {exeOpsPkg::mdDiv, exeOpsPkg::mdDivu}) ? '1 : a;
		if (op inside {exeOpsPkg::mdDiv, exeOpsPkg::mdRem} && a == 32'h8000_0000 && b == '1)
			return (op == exeOpsPkg::mdDiv) ? a : '0;
		case (op)
			exeOpsPkg::mdDiv:  return (a[31] ^ b[31]) ? -(magA / magB) : magA / magB;
			exeOpsPkg::mdDivu: return a / b;
			exeOpsPkg::mdRem:  return a[31] ? -(magA % magB) : magA % magB;
			default:           return a % b;
		endcase
	endfunction

	function automatic rvTypesPkg::word_t loadFrom(input exeOpsPkg::memOp_t op,
		input rvTypesPkg::word_t word, input logic [1:0] off);
		logic [7:0]  b8;
		logic [15:0] h16;
		b8  = word[8*off +: 8];
		h16 = off[1] ? word[31:16] : word[15:0];
		case (op)
			exeOpsPkg::memLb:  return {{24{b8[7]}}, b8};
			exeOpsPkg::memLbu: return {24'b0, b8};
			exeOpsPkg::memLh:  return {{16{h16[15]}}, h16};
			exeOpsPkg::memLhu: return {16'b0, h16};
			default:           return word;
		endcase
	endfunction

	function automatic rvTypesPkg::word_t storeInto(input exeOpsPkg::memOp_t op,
		input rvTypesPkg::word_t word, input rvTypesPkg::word_t data, input logic [1:0] off);
		rvTypesPkg::word_t w;
		w = word;
		case (op)
			exeOpsPkg::memSb: w[8*off +: 8] = data[7:0];
			exeOpsPkg::memSh: w[16*off[1] +: 16] = data[15:0];
			default:          w = data;
		endcase
		return w;
	endfunction

	// drives one instruction and queues what the model expects from it
	task automatic issue(input instr_t ins);
		expect_t           e;
		rvTypesPkg::word_t addr;
		int                idx;
		logic              isLoad;
		logic              isStore;
		isStore = ins.memOp inside {exeOpsPkg::memSb, exeOpsPkg::memSh, exeOpsPkg::memSw};
		isLoad  = ins.memOp inside {exeOpsPkg::memLb, exeOpsPkg::memLh, exeOpsPkg::memLw,
			exeOpsPkg::memLbu, exeOpsPkg::memLhu};
		addr    = ins.opA + (isStore ? ins.sImm : ins.opB);
		idx     = (addr >> 2) % memWords;
		e.valid = 1'b1;
		e.rd    = ins.rd;
		e.we    = ins.regWe;
		e.mis   = (ins.memOp inside {exeOpsPkg::memLh, exeOpsPkg::memLhu, exeOpsPkg::memSh}
			&& addr[0]) || (ins.memOp inside {exeOpsPkg::memLw, exeOpsPkg::memSw}
			&& addr[1:0] != 2'b00);
		case (ins.wbSel)
			exeOpsPkg::wbPcNext:    e.data = ins.pc + 32'd4;
			exeOpsPkg::wbMulDivRes: e.data = refMulDiv(ins.mulDivOp, ins.opA, ins.opB);
			exeOpsPkg::wbUpperImm:  e.data = ins.uImm;
			exeOpsPkg::wbMemData:   e.data = loadFrom(ins.memOp, shadow[idx], addr[1:0]);
			exeOpsPkg::wbAuipcRes:  e.data = ins.pc + ins.uImm;
			default:                e.data = refAlu(ins.aluOp, ins.opA, ins.opB);
		endcase
		e.chkData = !(ins.wbSel == exeOpsPkg::wbMemData && (!isLoad || e.mis));
		if (isStore && !e.mis)
			shadow[idx] = storeInto(ins.memOp, shadow[idx], ins.opB, addr[1:0]);
		e.taken = ins.isJal || ins.isJalr
			|| (ins.isBranch && refCond(ins.branchCmp, ins.branchNeg, ins.opA, ins.opB));
		if (ins.isJalr)
			e.target = (ins.opA + ins.opB) & ~32'd1;
		else
			e.target = ins.pc + (ins.isJal ? ins.jImm : ins.bImm);
		@(posedge clk);
		cur   <= ins;
		expIn <= e;
	endtask

	task automatic drain();
		repeat (drainLen)
			issue('0);
		@(negedge clk); // let the last checks run
	endtask

	task automatic reportTest(input string name);
		int errs;
		errs       = errCount - errAtStart;
		errAtStart = errCount;
		testsRun++;
		if (errs == 0)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: %0d mismatches", name, errs);
		end
	endtask

	task automatic checkResetState();
		assert (wbWe === 1'b0) else reportMismatch("wbWe", 0, wbWe);
		assert (branchTaken === 1'b0) else reportMismatch("branchTaken", 0, branchTaken);
		assert (addrMisaligned === 1'b0) else reportMismatch("addrMisaligned", 0, addrMisaligned);
		assert (wbData === '0) else reportMismatch("wbData", 0, wbData);
	endtask

	task automatic runAlu();
		instr_t ins;
		for (int i = 0; i < aluCount; i++)
		begin
			ins       = '0;
			ins.opA   = $random(seed);
			ins.opB   = $random(seed);
			ins.aluOp = exeOpsPkg::aluOp_t'(i % 10);
			ins.rd    = 5'($random(seed));
			ins.regWe = 1'($random(seed));
			issue(ins);
		end
	endtask

	task automatic runMulDiv();
		instr_t ins;
		for (int i = 0; i < mdCount + 6; i++)
		begin
			ins          = '0;
			ins.opA      = $random(seed);
			ins.opB      = (i % 5 == 0) ? ($random(seed) >>> 28) : $random(seed);
			ins.mulDivOp = exeOpsPkg::mulDivOp_t'(i % 8);
			if (i >= mdCount + 2)
				ins.opB = '0; // divide by zero, all four div/rem ops
			else if (i >= mdCount)
			begin
				ins.opA      = 32'h8000_0000;
				ins.opB      = '1;
				ins.mulDivOp = (i == mdCount) ? exeOpsPkg::mdDiv : exeOpsPkg::mdRem;
			end
			if (i >= mdCount + 2)
				ins.mulDivOp = exeOpsPkg::mulDivOp_t'(4 + i - mdCount - 2);
			ins.rd    = 5'($random(seed));
			ins.regWe = 1'b1;
			ins.wbSel = exeOpsPkg::wbMulDivRes;
			issue(ins);
		end
	endtask

	task automatic runBranches();
		instr_t            ins;
		rvTypesPkg::word_t a;
		rvTypesPkg::word_t b;
		for (int c = 0; c < 6; c++)
			for (int r = 0; r < brReps; r++)
			begin
				a = $random(seed);
				b = (r == 0) ? (a ^ 32'h8000_0000) : $random(seed); // signed vs unsigned split
				for (int k = 0; k < 3; k++)
				begin
					ins           = '0;
					ins.isBranch  = 1'b1;
					ins.branchCmp = exeOpsPkg::branchCmp_t'(c / 2);
					ins.branchNeg = 1'(c % 2);
					ins.opA       = (k == 2) ? b : a; // equal, then both orders
					ins.opB       = (k == 1) ? b : a;
					ins.pc        = $random(seed) & ~32'd3;
					ins.bImm      = ($random(seed) >>> 19) & ~32'd1;
					issue(ins);
				end
			end
		for (int j = 0; j < 4; j++)
		begin
			ins        = '0;
			ins.isJal  = (j < 2);
			ins.isJalr = (j >= 2);
			ins.opA    = $random(seed);
			ins.opB    = $random(seed) >>> 20;
			ins.jImm   = ($random(seed) >>> 11) & ~32'd1;
			ins.pc     = $random(seed) & ~32'd3;
			ins.rd     = 5'($random(seed));
			ins.regWe  = 1'b1;
			ins.wbSel  = exeOpsPkg::wbPcNext;
			issue(ins);
		end
	endtask

	task automatic runMemory();
		instr_t            ins;
		rvTypesPkg::word_t base;
		logic [1:0]        off;
		for (int w = 0; w < memWords; w++)
		begin
			ins       = '0;
			ins.memOp = exeOpsPkg::memSw;
			ins.opA   = w * 4;
			ins.opB   = (w * 32'h0101_0101) ^ 32'h5a3c_96e1;
			issue(ins);
		end
		for (int i = 0; i < memRounds; i++)
		begin
			base      = ($unsigned($random(seed)) % memWords) * 4;
			off       = 2'($random(seed));
			ins       = '0;
			ins.memOp = exeOpsPkg::memOp_t'(6 + i % 3); // sb, sh, sw
			off       = (i % 3 == 0) ? off : ((i % 3 == 1) ? (off & 2'b10) : 2'b00);
			ins.sImm  = $random(seed) >>> 22;
			ins.opA   = base + off - ins.sImm;
			ins.opB   = $random(seed);
			issue(ins);
			for (int k = 0; k < 5; k++)
			begin
				ins       = '0;
				ins.memOp = exeOpsPkg::memOp_t'(k + 1);
				off       = 2'($random(seed));
				if (ins.memOp inside {exeOpsPkg::memLh, exeOpsPkg::memLhu})
					off = off & 2'b10;
				else if (ins.memOp == exeOpsPkg::memLw)
					off = 2'b00;
				ins.opB   = $random(seed) >>> 22;
				ins.opA   = base + off - ins.opB;
				ins.rd    = 5'($random(seed));
				ins.regWe = 1'b1;
				ins.wbSel = exeOpsPkg::wbMemData;
				issue(ins);
			end
		end
		for (int i = 0; i < misRounds; i++)
		begin
			base      = ($unsigned($random(seed)) % memWords) * 4;
			ins       = '0;
			ins.memOp = (i % 2) ? exeOpsPkg::memSw : exeOpsPkg::memSh;
			ins.opA   = base + ((i % 2) ? (1 + i % 3) : (1 + (i & 2)));
			ins.opB   = $random(seed);
			issue(ins);
			ins       = '0; // word must be unchanged
			ins.memOp = exeOpsPkg::memLw;
			ins.opA   = base;
			ins.regWe = 1'b1;
			ins.wbSel = exeOpsPkg::wbMemData;
			issue(ins);
			ins.memOp = exeOpsPkg::memOp_t'((i % 3 == 0) ? 3 : 2 + 3 * (i % 2));
			ins.opA   = base + 1 + (i & 2);
			issue(ins);
		end
	endtask

	task automatic runWriteback();
		instr_t ins;
		for (int i = 0; i < 12; i++)
		begin
			ins       = '0;
			ins.pc    = $random(seed) & ~32'd3;
			ins.uImm  = $random(seed) & ~32'hfff;
			ins.rd    = 5'($random(seed));
			ins.regWe = 1'b1;
			ins.wbSel = (i % 3 == 0) ? exeOpsPkg::wbPcNext
				: ((i % 3 == 1) ? exeOpsPkg::wbUpperImm : exeOpsPkg::wbAuipcRes);
			issue(ins);
		end
	endtask

	initial
	begin
		nrst  = 1'b0;
		cur   = '0;
		expIn = '0;
		repeat (5)
		begin
			@(negedge clk);
			checkResetState();
		end
		@(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		checkResetState();
		reportTest("reset");
		runAlu();
		drain();
		reportTest("alu");
		runMulDiv();
		drain();
		reportTest("muldiv");
		runBranches();
		drain();
		reportTest("branch");
		runMemory();
		drain();
		reportTest("memory");
		runWriteback();
		drain();
		reportTest("writeback");
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		wait (cycleCount >= cycleLimit);
		$display("timeout after %0d cycles, the tests did not finish", cycleCount);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
